//--- src/mips_pkg.sv
package mips_pkg;

    // Instruction field widths
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 16;

    // Supported primary opcodes
    typedef enum logic [OPCODE_W-1:0] {
        OP_R_TYPE = 6'h00,
        OP_BEQ    = 6'h04,
        OP_BNE    = 6'h05,
        OP_ADDI   = 6'h08,
        OP_ADDIU  = 6'h09,
        OP_SLTI   = 6'h0a,
        OP_ANDI   = 6'h0c,
        OP_ORI    = 6'h0d,
        OP_XORI   = 6'h0e,
        OP_LUI    = 6'h0f,
        OP_HALT   = 6'h3f
    } opcode_e;

    // R-type function codes
    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

endpackage

//--- src/ctl_if.sv
`timescale 1ns/1ns

interface ctl_if import mips_pkg::*; ();

    alu_op_e alu_op;
    logic    alu_src_imm;
    logic    zero_ext;
    logic    reg_dst_rd;
    logic    reg_write;
    logic    branch;
    logic    branch_ne;
    logic    halt;

    modport decoder (
        output alu_op, alu_src_imm, zero_ext, reg_dst_rd,
        output reg_write, branch, branch_ne, halt
    );

    modport execute (
        input  alu_op, alu_src_imm, zero_ext, reg_dst_rd,
        input  reg_write, branch, branch_ne, halt
    );

endinterface

//--- src/mips_fetch.sv
`timescale 1ns/1ns

module mips_fetch #(
    parameter  int DATA_W     = 32,
    parameter  int IMEM_DEPTH = 256,
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH)
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_step,
    input  logic               i_load_we,
    input  logic [IMEM_AW-1:0] i_load_addr,
    input  logic [DATA_W-1:0]  i_load_data,
    input  logic               i_halt_req,
    input  logic [DATA_W-1:0]  i_pc_next,
    output logic [DATA_W-1:0]  o_pc,
    output logic [DATA_W-1:0]  o_instr,
    output logic               o_commit,
    output logic               o_halted
);

    logic [DATA_W-1:0]  imem [IMEM_DEPTH];
    logic [DATA_W-1:0]  pc;
    logic               halted;
    logic [IMEM_AW-1:0] pc_word;

    // Byte address to word index
    assign pc_word = pc[IMEM_AW+1:2];

    // Debug load port, independent of reset and step
    always_ff @(posedge i_clk) begin
        if (i_load_we) begin
            imem[i_load_addr] <= i_load_data;
        end
    end

    assign o_instr = imem[pc_word];

    // One instruction retires per stepped cycle
    assign o_commit = i_step & ~halted;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (o_commit) begin
            pc <= i_pc_next;
            if (i_halt_req) begin
                halted <= 1'b1;
            end
        end
    end

    assign o_pc     = pc;
    assign o_halted = halted;

endmodule

//--- src/mips_control.sv
`timescale 1ns/1ns

module mips_control import mips_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic [DATA_W-1:0] i_instr,
    ctl_if.decoder            ctl,
    output logic              o_halt_req
);

    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT_W-1:0]  funct;
    logic                halt_dec;

    assign opcode = i_instr[DATA_W-1 -: OPCODE_W];
    assign funct  = i_instr[FUNCT_W-1:0];

    always_comb begin
        ctl.alu_op      = ALU_ADD;
        ctl.alu_src_imm = 1'b0;
        ctl.zero_ext    = 1'b0;
        ctl.reg_dst_rd  = 1'b0;
        ctl.reg_write   = 1'b0;
        ctl.branch      = 1'b0;
        ctl.branch_ne   = 1'b0;
        halt_dec        = 1'b0;

        case (opcode)
            OP_R_TYPE: begin
                ctl.reg_dst_rd = 1'b1;
                ctl.reg_write  = 1'b1;
                case (funct)
                    FN_ADD, FN_ADDU: ctl.alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: ctl.alu_op = ALU_SUB;
                    FN_AND:          ctl.alu_op = ALU_AND;
                    FN_OR:           ctl.alu_op = ALU_OR;
                    FN_XOR:          ctl.alu_op = ALU_XOR;
                    FN_NOR:          ctl.alu_op = ALU_NOR;
                    FN_SLT:          ctl.alu_op = ALU_SLT;
                    FN_SLL:          ctl.alu_op = ALU_SLL;
                    FN_SRL:          ctl.alu_op = ALU_SRL;
                    FN_SRA:          ctl.alu_op = ALU_SRA;
                    default: begin
                        // Unsupported funct behaves as a no-op
                        ctl.reg_dst_rd = 1'b0;
                        ctl.reg_write  = 1'b0;
                    end
                endcase
            end
            OP_ADDI, OP_ADDIU: begin
                ctl.alu_src_imm = 1'b1;
                ctl.reg_write   = 1'b1;
            end
            OP_SLTI: begin
                ctl.alu_op      = ALU_SLT;
                ctl.alu_src_imm = 1'b1;
                ctl.reg_write   = 1'b1;
            end
            OP_ANDI: begin
                ctl.alu_op      = ALU_AND;
                ctl.alu_src_imm = 1'b1;
                ctl.zero_ext    = 1'b1;
                ctl.reg_write   = 1'b1;
            end
            OP_ORI: begin
                ctl.alu_op      = ALU_OR;
                ctl.alu_src_imm = 1'b1;
                ctl.zero_ext    = 1'b1;
                ctl.reg_write   = 1'b1;
            end
            OP_XORI: begin
                ctl.alu_op      = ALU_XOR;
                ctl.alu_src_imm = 1'b1;
                ctl.zero_ext    = 1'b1;
                ctl.reg_write   = 1'b1;
            end
            OP_LUI: begin
                ctl.alu_op      = ALU_LUI;
                ctl.alu_src_imm = 1'b1;
                ctl.reg_write   = 1'b1;
            end
            // Branches compare through subtraction
            OP_BEQ: begin
                ctl.alu_op = ALU_SUB;
                ctl.branch = 1'b1;
            end
            OP_BNE: begin
                ctl.alu_op    = ALU_SUB;
                ctl.branch    = 1'b1;
                ctl.branch_ne = 1'b1;
            end
            OP_HALT: halt_dec = 1'b1;
            default: ;
        endcase
    end

    assign ctl.halt   = halt_dec;
    assign o_halt_req = halt_dec;

endmodule

//--- src/mips_regfile.sv
`timescale 1ns/1ns

module mips_regfile import mips_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic [REG_ADDR_W-1:0] i_rs_addr,
    input  logic [REG_ADDR_W-1:0] i_rt_addr,
    input  logic [REG_ADDR_W-1:0] i_dbg_addr,
    input  logic                  i_we,
    input  logic [REG_ADDR_W-1:0] i_wr_addr,
    input  logic [DATA_W-1:0]     i_wr_data,
    output logic [DATA_W-1:0]     o_rs_data,
    output logic [DATA_W-1:0]     o_rt_data,
    output logic [DATA_W-1:0]     o_dbg_data
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_wr_addr != '0)) begin
            // r0 is hardwired to zero
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Combinational reads
    assign o_rs_data  = regs[i_rs_addr];
    assign o_rt_data  = regs[i_rt_addr];
    assign o_dbg_data = regs[i_dbg_addr];

endmodule

//--- src/mips_execute.sv
`timescale 1ns/1ns

module mips_execute import mips_pkg::*; #(
    parameter int DATA_W = 32
) (
    ctl_if.execute                ctl,
    input  logic [DATA_W-1:0]     i_instr,
    input  logic [DATA_W-1:0]     i_pc,
    input  logic                  i_commit,
    input  logic [DATA_W-1:0]     i_rs_data,
    input  logic [DATA_W-1:0]     i_rt_data,
    output logic [REG_ADDR_W-1:0] o_rs_addr,
    output logic [REG_ADDR_W-1:0] o_rt_addr,
    output logic                  o_we,
    output logic [REG_ADDR_W-1:0] o_wr_addr,
    output logic [DATA_W-1:0]     o_wr_data,
    output logic [DATA_W-1:0]     o_pc_next
);

    logic [REG_ADDR_W-1:0] rd_addr;
    logic [SHAMT_W-1:0]    shamt;
    logic [IMM_W-1:0]      imm;
    logic [DATA_W-1:0]     imm_ext;
    logic [DATA_W-1:0]     op_b;
    logic [DATA_W-1:0]     alu_result;
    logic                  alu_zero;
    logic                  branch_taken;
    logic [DATA_W-1:0]     pc_plus4;
    logic [DATA_W-1:0]     pc_branch;

    // Instruction fields
    assign o_rs_addr = i_instr[IMM_W+2*REG_ADDR_W-1 -: REG_ADDR_W];
    assign o_rt_addr = i_instr[IMM_W+REG_ADDR_W-1 -: REG_ADDR_W];
    assign rd_addr   = i_instr[IMM_W-1 -: REG_ADDR_W];
    assign shamt     = i_instr[IMM_W-REG_ADDR_W-1 -: SHAMT_W];
    assign imm       = i_instr[IMM_W-1:0];

    // Logic immediates are zero extended
    assign imm_ext = ctl.zero_ext ? {{(DATA_W-IMM_W){1'b0}}, imm}
                                  : {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};

    assign op_b = ctl.alu_src_imm ? imm_ext : i_rt_data;

    always_comb begin
        case (ctl.alu_op)
            ALU_ADD: alu_result = i_rs_data + op_b;
            ALU_SUB: alu_result = i_rs_data - op_b;
            ALU_AND: alu_result = i_rs_data & op_b;
            ALU_OR:  alu_result = i_rs_data | op_b;
            ALU_XOR: alu_result = i_rs_data ^ op_b;
            ALU_NOR: alu_result = ~(i_rs_data | op_b);
            ALU_SLT: begin
                alu_result = {{(DATA_W-1){1'b0}},
                              ($signed(i_rs_data) < $signed(op_b))};
            end
            // Shifts act on rt
            ALU_SLL: alu_result = op_b << shamt;
            ALU_SRL: alu_result = op_b >> shamt;
            ALU_SRA: alu_result = $signed(op_b) >>> shamt;
            ALU_LUI: alu_result = op_b << IMM_W;
            default: alu_result = '0;
        endcase
    end

    assign alu_zero = (alu_result == '0);

    // Write-back
    assign o_we      = ctl.reg_write & i_commit;
    assign o_wr_addr = ctl.reg_dst_rd ? rd_addr : o_rt_addr;
    assign o_wr_data = alu_result;

    // Next PC
    assign pc_plus4     = i_pc + DATA_W'(4);
    assign pc_branch    = pc_plus4 + (imm_ext << 2);
    assign branch_taken = ctl.branch & (ctl.branch_ne ? ~alu_zero : alu_zero);

    always_comb begin
        if (ctl.halt) begin
            // Halt keeps the PC on the halt instruction
            o_pc_next = i_pc;
        end else if (branch_taken) begin
            o_pc_next = pc_branch;
        end else begin
            o_pc_next = pc_plus4;
        end
    end

endmodule

//--- src/mips_top.sv
`timescale 1ns/1ns

module mips_top import mips_pkg::*; #(
    parameter int DATA_W     = 32,
    parameter int IMEM_DEPTH = 256
) (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_step,
    input  logic                           i_load_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0]  i_load_addr,
    input  logic [DATA_W-1:0]              i_load_data,
    input  logic [REG_ADDR_W-1:0]          i_dbg_reg_addr,
    output logic [DATA_W-1:0]              o_pc,
    output logic [DATA_W-1:0]              o_dbg_reg_data,
    output logic                           o_halt
);

    logic [DATA_W-1:0]     instr;
    logic [DATA_W-1:0]     pc;
    logic [DATA_W-1:0]     pc_next;
    logic                  commit;
    logic                  halt_req;
    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    logic [DATA_W-1:0]     rs_data;
    logic [DATA_W-1:0]     rt_data;
    logic                  wr_en;
    logic [REG_ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0]     wr_data;

    ctl_if ctl_bus ();

    mips_fetch #(
        .DATA_W     (DATA_W),
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_fetch (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_step      (i_step),
        .i_load_we   (i_load_we),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .i_halt_req  (halt_req),
        .i_pc_next   (pc_next),
        .o_pc        (pc),
        .o_instr     (instr),
        .o_commit    (commit),
        .o_halted    (o_halt)
    );

    mips_control #(
        .DATA_W (DATA_W)
    ) u_control (
        .i_instr    (instr),
        .ctl        (ctl_bus.decoder),
        .o_halt_req (halt_req)
    );

    mips_regfile #(
        .DATA_W (DATA_W)
    ) u_regfile (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rs_addr  (rs_addr),
        .i_rt_addr  (rt_addr),
        .i_dbg_addr (i_dbg_reg_addr),
        .i_we       (wr_en),
        .i_wr_addr  (wr_addr),
        .i_wr_data  (wr_data),
        .o_rs_data  (rs_data),
        .o_rt_data  (rt_data),
        .o_dbg_data (o_dbg_reg_data)
    );

    mips_execute #(
        .DATA_W (DATA_W)
    ) u_execute (
        .ctl       (ctl_bus.execute),
        .i_instr   (instr),
        .i_pc      (pc),
        .i_commit  (commit),
        .i_rs_data (rs_data),
        .i_rt_data (rt_data),
        .o_rs_addr (rs_addr),
        .o_rt_addr (rt_addr),
        .o_we      (wr_en),
        .o_wr_addr (wr_addr),
        .o_wr_data (wr_data),
        .o_pc_next (pc_next)
    );

    assign o_pc = pc;

endmodule

//--- sim/mips_chk.sv
`timescale 1ns/1ns

module mips_chk (
    input logic        i_clk,
    input logic        i_rst,
    input logic [4:0]  i_dbg_reg_addr,
    input logic [31:0] o_dbg_reg_data,
    input logic [31:0] o_pc,
    input logic        o_halt
);

    int fail_count = 0;

    // Halted core keeps its PC
    a_pc_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        o_halt |=> $stable(o_pc))
        else begin
            fail_count++;
            $error("PC moved while halted");
        end

    a_r0_zero: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_dbg_reg_addr == 5'd0) |-> (o_dbg_reg_data == 32'd0))
        else begin
            fail_count++;
            $error("Register 0 reads nonzero");
        end

    a_halt_reset: assert property (@(posedge i_clk) i_rst |=> !o_halt)
        else begin
            fail_count++;
            $error("Halt flag set after reset");
        end

endmodule

bind mips_top mips_chk u_chk (.*);

//--- sim/tb_mips.sv
`timescale 1ns/1ns

module tb_mips;

    localparam int    DATA_W     = 32;
    localparam int    IMEM_DEPTH = 256;
    localparam int    CLK_PERIOD = 20;
    localparam int    RST_CYCLES = 10;
    localparam string STIM_FILE  = "sim/mips_stim.txt";

    logic              i_clk;
    logic              i_rst;
    logic              i_step;
    logic              i_load_we;
    logic [7:0]        i_load_addr;
    logic [DATA_W-1:0] i_load_data;
    logic [4:0]        i_dbg_reg_addr;
    logic [DATA_W-1:0] o_pc;
    logic [DATA_W-1:0] o_dbg_reg_data;
    logic              o_halt;

    int          fd;
    int          code;
    int          seed = 35;
    int          cycles = 0;
    int          limit = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          rst_cycles = 0;
    int          idle;
    logic [31:0] arg_a;
    logic [31:0] arg_b;
    string       cmd;
    string       line;

    mips_top #(
        .DATA_W     (DATA_W),
        .IMEM_DEPTH (IMEM_DEPTH)
    ) DUT (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_step         (i_step),
        .i_load_we      (i_load_we),
        .i_load_addr    (i_load_addr),
        .i_load_data    (i_load_data),
        .i_dbg_reg_addr (i_dbg_reg_addr),
        .o_pc           (o_pc),
        .o_dbg_reg_data (o_dbg_reg_data),
        .o_halt         (o_halt)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // Run limit
    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    task automatic tick();
        @(posedge i_clk);
        #2;
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_reg(input logic [4:0] idx, input logic [31:0] expected);
        i_dbg_reg_addr = idx;
        #1;
        compare($sformatf("o_dbg_reg_data[r%0d]", idx), expected, o_dbg_reg_data);
    endtask

    // Leaves reset once it has lasted long enough, then steps
    task automatic run_steps(input int n, input logic level);
        if (i_rst) begin
            while (rst_cycles < RST_CYCLES) begin
                tick();
                rst_cycles++;
            end
            i_rst = 1'b0;
        end
        if (level) begin
            idle = {$random(seed)} % 4;
            repeat (idle) tick();
        end
        i_step = level;
        repeat (n) tick();
        i_step = 1'b0;
    endtask

    task automatic set_limit();
        int total;
        total = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file %s", STIM_FILE);
            $display("Something failed");
            $finish;
        end
        while ($fscanf(fd, " %s", cmd) == 1) begin
            if (cmd == "#") begin
                code = $fgets(line, fd);
            end else if (cmd == "S") begin
                code = $fscanf(fd, " %h %h", arg_a, arg_b);
                total += int'(arg_a);
            end
        end
        $fclose(fd);
        limit = 2 * total + 200;
    endtask

    initial begin
        i_rst          = 1'b1;
        i_step         = 1'b0;
        i_load_we      = 1'b0;
        i_load_addr    = '0;
        i_load_data    = '0;
        i_dbg_reg_addr = '0;
        set_limit();
        fd = $fopen(STIM_FILE, "r");
        while ($fscanf(fd, " %s", cmd) == 1) begin
            case (cmd)
                "#": code = $fgets(line, fd);
                "R": begin
                    i_rst      = 1'b1;
                    i_step     = 1'b0;
                    rst_cycles = 0;
                end
                "L": begin
                    code        = $fscanf(fd, " %h %h", arg_a, arg_b);
                    i_load_we   = 1'b1;
                    i_load_addr = arg_a[7:0];
                    i_load_data = arg_b;
                    tick();
                    rst_cycles++;
                    i_load_we = 1'b0;
                end
                "S": begin
                    code = $fscanf(fd, " %h %h", arg_a, arg_b);
                    run_steps(int'(arg_a), arg_b[0]);
                end
                "C": begin
                    code = $fscanf(fd, " %h %h", arg_a, arg_b);
                    check_reg(arg_a[4:0], arg_b);
                end
                "P": begin
                    code = $fscanf(fd, " %h", arg_a);
                    compare("o_pc", arg_a, o_pc);
                end
                "H": begin
                    code = $fscanf(fd, " %h", arg_a);
                    compare("o_halt", arg_a, {31'b0, o_halt});
                end
                "T": begin
                    code = $fscanf(fd, " %s", line);
                    tests++;
                    if (test_errors != 0) failed_tests++;
                    $display("Test %s: %s", line, (test_errors == 0) ? "passed" : "failed");
                    test_errors = 0;
                end
                default: begin
                    $display("Unknown command %s in stimulus file", cmd);
                    errors++;
                end
            endcase
        end
        $fclose(fd);
        $display("Tests %0d, failed %0d, mismatches %0d, assertion failures %0d",
                 tests, failed_tests, errors, DUT.u_chk.fail_count);
        if (errors == 0 && DUT.u_chk.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- sim/mips_stim.txt
# R reset, L word_addr word, S cycles step_level, C reg value, P pc, H halt, T test_name
# All numbers are hex; loads happen while reset is held
R L 0 20010005 L 1 2002fffd L 2 00221820 L 3 00222022 L 4 00222824
L 5 00223025 L 6 00223826 L 7 00224027 L 8 0041482a L 9 00025100
L a 00025f02 L b 00026043 L c fc000000
S 10 1
C 3 2 C 4 8 C 5 5 C 6 fffffffd C 7 fffffff8 C 8 2 C 9 1
C a ffffffd0 C b f C c fffffffe P 30 H 1
T r_type
R L 0 2001ffff L 1 28220001 L 2 30238000 L 3 34048001 L 4 3825ffff
L 5 3c068234 L 6 fc000000
S c 1
C 1 ffffffff C 2 1 C 3 8000 C 4 8001 C 5 ffff0000 C 6 82340000 H 1
T immediates
R L 0 20010001 L 1 20020001 L 2 10220001 L 3 20030007 L 4 14220001
L 5 20040009 L 6 14200001 L 7 20050003 L 8 fc000000
S c 1
C 3 0 C 4 9 C 5 0 P 20 H 1
T branches
R L 0 20000005 L 1 00000820 L 2 fc000000
S 5 1
C 0 0 C 1 0 P 8
T reg_zero
R L 0 20010001 L 1 20210001 L 2 fc000000
S 1 1 C 1 1 P 4
S 7 0 C 1 1 P 4 H 0
S 1 1 C 1 2 P 8
S 3 1 C 1 2 P 8 H 1
T step_hold
R L 0 20010005 L 1 fc000000
S 4 1 C 1 5 P 4 H 1
S 5 1 C 1 5 P 4 H 1
R S 0 0 P 0 H 0 C 1 0
T halt_reset

//--- flist.f
src/mips_pkg.sv
src/ctl_if.sv
src/mips_fetch.sv
src/mips_control.sv
src/mips_regfile.sv
src/mips_execute.sv
src/mips_top.sv
sim/mips_chk.sv
sim/tb_mips.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
